// ==== source/mips_pkg.sv ====
package mips_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // primary opcodes, inst[31:26]
  localparam logic [5:0] OP_SPECIAL = 6'b000000;
  localparam logic [5:0] OP_ORI     = 6'b001101;
  localparam logic [5:0] OP_ANDI    = 6'b001100;
  localparam logic [5:0] OP_XORI    = 6'b001110;
  localparam logic [5:0] OP_LUI     = 6'b001111;
  localparam logic [5:0] OP_SLTI    = 6'b001010;
  localparam logic [5:0] OP_SLTIU   = 6'b001011;
  localparam logic [5:0] OP_ADDI    = 6'b001000;
  localparam logic [5:0] OP_ADDIU   = 6'b001001;

  // SPECIAL funct codes, inst[5:0]
  localparam logic [5:0] FN_OR   = 6'b100101;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_XOR  = 6'b100110;
  localparam logic [5:0] FN_NOR  = 6'b100111;
  localparam logic [5:0] FN_SLLV = 6'b000100;
  localparam logic [5:0] FN_SRLV = 6'b000110;
  localparam logic [5:0] FN_SRAV = 6'b000111;
  localparam logic [5:0] FN_SLL  = 6'b000000;
  localparam logic [5:0] FN_SRL  = 6'b000010;
  localparam logic [5:0] FN_SRA  = 6'b000011;
  localparam logic [5:0] FN_SLT  = 6'b101010;
  localparam logic [5:0] FN_SLTU = 6'b101011;
  localparam logic [5:0] FN_ADD  = 6'b100000;
  localparam logic [5:0] FN_ADDU = 6'b100001;
  localparam logic [5:0] FN_SUB  = 6'b100010;
  localparam logic [5:0] FN_SUBU = 6'b100011;

  typedef enum logic [3:0] {
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_NOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_ADD,
    ALU_SUB,
    ALU_NOP
  } alu_op_e;

  // decode stage register
  typedef struct packed {
    alu_op_e   alu_op;
    logic      rs_read;
    logic      rt_read;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t dest;
    logic      wr_en;
    word_t     imm;
  } decoded_t;

  // operand stage register, operands already resolved
  typedef struct packed {
    alu_op_e   alu_op;
    word_t     a;
    word_t     b;
    reg_addr_t dest;
    logic      wr_en;
  } operand_t;

  // retire record, doubles as the write-back bus
  typedef struct packed {
    logic      wr_en;
    reg_addr_t dest;
    word_t     data;
  } retire_t;

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               inst_req_i,
  input  mips_pkg::word_t    inst_i,
  output logic               inst_ack_o,
  output logic               dec_valid_o,
  output mips_pkg::decoded_t dec_o
);

  logic [5:0]  op;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [4:0]  shamt;
  logic [5:0]  funct;
  logic [15:0] imm16;

  mips_pkg::word_t    imm_zext;
  mips_pkg::word_t    imm_sext;
  mips_pkg::alu_op_e  r_alu;
  logic               r_known;
  mips_pkg::alu_op_e  sh_alu;
  logic               sh_known;
  mips_pkg::decoded_t dec_next;
  logic               accept;

  assign op    = inst_i[31:26];
  assign rs    = inst_i[25:21];
  assign rt    = inst_i[20:16];
  assign rd    = inst_i[15:11];
  assign shamt = inst_i[10:6];
  assign funct = inst_i[5:0];
  assign imm16 = inst_i[15:0];

  assign imm_zext = {16'b0, imm16};
  assign imm_sext = {{16{imm16[15]}}, imm16};

  // new request seen while ack is still low
  assign accept = inst_req_i & ~inst_ack_o;

  // register-form ops, valid only with shamt zero
  always_comb begin
    r_known = 1'b1;
    case (funct)
      mips_pkg::FN_OR:   r_alu = mips_pkg::ALU_OR;
      mips_pkg::FN_AND:  r_alu = mips_pkg::ALU_AND;
      mips_pkg::FN_XOR:  r_alu = mips_pkg::ALU_XOR;
      mips_pkg::FN_NOR:  r_alu = mips_pkg::ALU_NOR;
      mips_pkg::FN_SLLV: r_alu = mips_pkg::ALU_SLL;
      mips_pkg::FN_SRLV: r_alu = mips_pkg::ALU_SRL;
      mips_pkg::FN_SRAV: r_alu = mips_pkg::ALU_SRA;
      mips_pkg::FN_SLT:  r_alu = mips_pkg::ALU_SLT;
      mips_pkg::FN_SLTU: r_alu = mips_pkg::ALU_SLTU;
      mips_pkg::FN_ADD, mips_pkg::FN_ADDU: r_alu = mips_pkg::ALU_ADD;
      mips_pkg::FN_SUB, mips_pkg::FN_SUBU: r_alu = mips_pkg::ALU_SUB;
      default: begin
        r_alu   = mips_pkg::ALU_NOP;
        r_known = 1'b0;
      end
    endcase
  end

  // shift by shamt
  always_comb begin
    sh_known = 1'b1;
    case (funct)
      mips_pkg::FN_SLL: sh_alu = mips_pkg::ALU_SLL;
      mips_pkg::FN_SRL: sh_alu = mips_pkg::ALU_SRL;
      mips_pkg::FN_SRA: sh_alu = mips_pkg::ALU_SRA;
      default: begin
        sh_alu   = mips_pkg::ALU_NOP;
        sh_known = 1'b0;
      end
    endcase
  end

  always_comb begin
    dec_next         = '0;
    dec_next.alu_op  = mips_pkg::ALU_NOP;
    dec_next.rs_addr = rs;
    dec_next.rt_addr = rt;
    dec_next.dest    = rd;

    if (op == mips_pkg::OP_SPECIAL && shamt == 5'd0 && r_known) begin
      dec_next.alu_op  = r_alu;
      dec_next.rs_read = 1'b1;
      dec_next.rt_read = 1'b1;
      dec_next.wr_en   = 1'b1;
    end else if (inst_i[31:21] == 11'd0 && sh_known) begin
      // rs unread, so a picks up shamt
      dec_next.alu_op  = sh_alu;
      dec_next.rt_read = 1'b1;
      dec_next.imm     = {{(mips_pkg::WORD_W-5){1'b0}}, shamt};
      dec_next.wr_en   = 1'b1;
    end else begin
      // I-type: rt is the target, b takes imm
      dec_next.dest    = rt;
      dec_next.rs_read = 1'b1;
      dec_next.wr_en   = 1'b1;
      case (op)
        mips_pkg::OP_ORI: begin
          dec_next.alu_op = mips_pkg::ALU_OR;
          dec_next.imm    = imm_zext;
        end
        mips_pkg::OP_ANDI: begin
          dec_next.alu_op = mips_pkg::ALU_AND;
          dec_next.imm    = imm_zext;
        end
        mips_pkg::OP_XORI: begin
          dec_next.alu_op = mips_pkg::ALU_XOR;
          dec_next.imm    = imm_zext;
        end
        mips_pkg::OP_LUI: begin
          // both operands equal the shifted imm
          dec_next.alu_op  = mips_pkg::ALU_OR;
          dec_next.rs_read = 1'b0;
          dec_next.imm     = {imm16, 16'h0};
        end
        mips_pkg::OP_SLTI: begin
          dec_next.alu_op = mips_pkg::ALU_SLT;
          dec_next.imm    = imm_sext;
        end
        mips_pkg::OP_SLTIU: begin
          dec_next.alu_op = mips_pkg::ALU_SLTU;
          dec_next.imm    = imm_sext;
        end
        mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
          dec_next.alu_op = mips_pkg::ALU_ADD;
          dec_next.imm    = imm_sext;
        end
        default: begin
          dec_next.rs_read = 1'b0;
          dec_next.wr_en   = 1'b0;
        end
      endcase
    end

    // r0 is never a real target
    if (dec_next.dest == '0) begin
      dec_next.wr_en = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inst_ack_o  <= 1'b0;
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= accept;
      if (accept) begin
        inst_ack_o <= 1'b1;
      end else if (!inst_req_i) begin
        inst_ack_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_o <= dec_next;
    end
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                clk_i,
  input  logic                rst_i,
  input  mips_pkg::reg_addr_t rs_addr_i,
  input  mips_pkg::reg_addr_t rt_addr_i,
  input  mips_pkg::retire_t   wb_i,
  output mips_pkg::word_t     rs_data_o,
  output mips_pkg::word_t     rt_data_o
);

  localparam int NUM_REGS = 2 ** mips_pkg::REG_ADDR_W;

  mips_pkg::word_t regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.wr_en && wb_i.dest != '0) begin
      regs[wb_i.dest] <= wb_i.data;
    end
  end

  // r0 stays zero since it is never written
  assign rs_data_o = regs[rs_addr_i];
  assign rt_data_o = regs[rt_addr_i];

endmodule

// ==== source/operand_stage.sv ====
`timescale 1ns/1ns

module operand_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               dec_valid_i,
  input  mips_pkg::decoded_t dec_i,
  input  mips_pkg::retire_t  ex_fwd_i,
  input  mips_pkg::retire_t  wb_i,
  output logic               op_valid_o,
  output mips_pkg::operand_t op_o
);

  mips_pkg::word_t rs_data;
  mips_pkg::word_t rt_data;
  mips_pkg::word_t a_next;
  mips_pkg::word_t b_next;

  // younger result wins over the one being written back
  function automatic mips_pkg::word_t resolve(
    input logic                rd_en,
    input mips_pkg::reg_addr_t addr,
    input mips_pkg::word_t     rf_data,
    input mips_pkg::word_t     imm,
    input mips_pkg::retire_t   ex,
    input mips_pkg::retire_t   wb
  );
    if (!rd_en) begin
      return imm;
    end else if (ex.wr_en && ex.dest == addr) begin
      return ex.data;
    end else if (wb.wr_en && wb.dest == addr) begin
      return wb.data;
    end
    return rf_data;
  endfunction

  reg_file i_reg_file (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rs_addr_i (dec_i.rs_addr),
    .rt_addr_i (dec_i.rt_addr),
    .wb_i      (wb_i),
    .rs_data_o (rs_data),
    .rt_data_o (rt_data)
  );

  assign a_next = resolve(dec_i.rs_read, dec_i.rs_addr, rs_data, dec_i.imm, ex_fwd_i, wb_i);
  assign b_next = resolve(dec_i.rt_read, dec_i.rt_addr, rt_data, dec_i.imm, ex_fwd_i, wb_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_valid_o <= 1'b0;
    end else begin
      op_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_o.alu_op <= dec_i.alu_op;
    op_o.a      <= a_next;
    op_o.b      <= b_next;
    op_o.dest   <= dec_i.dest;
    // stale decode contents must not look like a write
    op_o.wr_en  <= dec_i.wr_en & dec_valid_i;
  end

endmodule

// ==== source/alu_stage.sv ====
`timescale 1ns/1ns

module alu_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               op_valid_i,
  input  mips_pkg::operand_t op_i,
  output mips_pkg::retire_t  fwd_o,
  output logic               ret_valid_o,
  output mips_pkg::retire_t  ret_o
);

  mips_pkg::word_t result;
  logic [4:0]      sa;

  // shift amount from a, value from b
  assign sa = op_i.a[4:0];

  always_comb begin
    case (op_i.alu_op)
      mips_pkg::ALU_OR:   result = op_i.a | op_i.b;
      mips_pkg::ALU_AND:  result = op_i.a & op_i.b;
      mips_pkg::ALU_XOR:  result = op_i.a ^ op_i.b;
      mips_pkg::ALU_NOR:  result = ~(op_i.a | op_i.b);
      mips_pkg::ALU_SLL:  result = op_i.b << sa;
      mips_pkg::ALU_SRL:  result = op_i.b >> sa;
      mips_pkg::ALU_SRA:  result = $signed(op_i.b) >>> sa;
      mips_pkg::ALU_SLT: begin
        result = {{(mips_pkg::WORD_W-1){1'b0}}, $signed(op_i.a) < $signed(op_i.b)};
      end
      mips_pkg::ALU_SLTU: begin
        result = {{(mips_pkg::WORD_W-1){1'b0}}, op_i.a < op_i.b};
      end
      // no overflow trap, both wrap
      mips_pkg::ALU_ADD:  result = op_i.a + op_i.b;
      mips_pkg::ALU_SUB:  result = op_i.a - op_i.b;
      default:            result = '0;
    endcase
  end

  assign fwd_o.wr_en = op_valid_i & op_i.wr_en;
  assign fwd_o.dest  = op_i.dest;
  assign fwd_o.data  = result;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ret_valid_o <= 1'b0;
      ret_o       <= '0;
    end else begin
      ret_valid_o <= op_valid_i;
      ret_o       <= fwd_o;
    end
  end

endmodule

// ==== source/mips_int_core.sv ====
`timescale 1ns/1ns

module mips_int_core (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              inst_req_i,
  input  mips_pkg::word_t   inst_i,
  output logic              inst_ack_o,
  output logic              ret_valid_o,
  output mips_pkg::retire_t ret_o
);

  logic               dec_valid;
  mips_pkg::decoded_t dec;
  logic               op_valid;
  mips_pkg::operand_t op;
  mips_pkg::retire_t  ex_fwd;
  mips_pkg::retire_t  ret;

  inst_decoder i_inst_decoder (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .inst_req_i  (inst_req_i),
    .inst_i      (inst_i),
    .inst_ack_o  (inst_ack_o),
    .dec_valid_o (dec_valid),
    .dec_o       (dec)
  );

  // retire register doubles as write port and older bypass
  operand_stage i_operand_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .ex_fwd_i    (ex_fwd),
    .wb_i        (ret),
    .op_valid_o  (op_valid),
    .op_o        (op)
  );

  alu_stage i_alu_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .fwd_o       (ex_fwd),
    .ret_valid_o (ret_valid_o),
    .ret_o       (ret)
  );

  assign ret_o = ret;

endmodule

// ==== dv/mips_ref_model.svh ====
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// architectural registers, r0 stays zero
mips_pkg::word_t model_regs [32];
logic [31:0]     lfsr_state;

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  repeat (n) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
  end
  return r;
endfunction

function automatic mips_pkg::word_t encode_r(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sa);
  return {mips_pkg::OP_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic mips_pkg::word_t encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

// executes one instruction on the model and returns its retire record
function automatic mips_pkg::retire_t ref_execute(input mips_pkg::word_t inst);
  mips_pkg::retire_t r;
  mips_pkg::word_t   s;
  mips_pkg::word_t   t;
  mips_pkg::word_t   se;
  logic              ok;
  logic              shift_imm;
  s         = model_regs[inst[25:21]];
  t         = model_regs[inst[20:16]];
  se        = {{16{inst[15]}}, inst[15:0]};
  r         = '0;
  r.dest    = inst[20:16];
  shift_imm = inst[5:0] inside {mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA};
  if (inst[31:26] == mips_pkg::OP_SPECIAL) begin
    r.dest = inst[15:11];
    // shift by shamt needs rs zero, all others need shamt zero
    ok = shift_imm ? (inst[25:21] == 5'd0) : (inst[10:6] == 5'd0);
    case (inst[5:0])
      mips_pkg::FN_OR:   r.data = s | t;
      mips_pkg::FN_AND:  r.data = s & t;
      mips_pkg::FN_XOR:  r.data = s ^ t;
      mips_pkg::FN_NOR:  r.data = ~(s | t);
      mips_pkg::FN_SLLV: r.data = t << s[4:0];
      mips_pkg::FN_SRLV: r.data = t >> s[4:0];
      mips_pkg::FN_SRAV: r.data = $signed(t) >>> s[4:0];
      mips_pkg::FN_SLL:  r.data = t << inst[10:6];
      mips_pkg::FN_SRL:  r.data = t >> inst[10:6];
      mips_pkg::FN_SRA:  r.data = $signed(t) >>> inst[10:6];
      mips_pkg::FN_SLT:  r.data = {31'b0, $signed(s) < $signed(t)};
      mips_pkg::FN_SLTU: r.data = {31'b0, s < t};
      mips_pkg::FN_ADD, mips_pkg::FN_ADDU: r.data = s + t;
      mips_pkg::FN_SUB, mips_pkg::FN_SUBU: r.data = s - t;
      default:           ok = 1'b0;
    endcase
  end else begin
    ok = 1'b1;
    case (inst[31:26])
      mips_pkg::OP_ORI:   r.data = s | {16'h0, inst[15:0]};
      mips_pkg::OP_ANDI:  r.data = s & {16'h0, inst[15:0]};
      mips_pkg::OP_XORI:  r.data = s ^ {16'h0, inst[15:0]};
      mips_pkg::OP_LUI:   r.data = {inst[15:0], 16'h0};
      mips_pkg::OP_SLTI:  r.data = {31'b0, $signed(s) < $signed(se)};
      mips_pkg::OP_SLTIU: r.data = {31'b0, s < se};
      mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: r.data = s + se;
      default:            ok = 1'b0;
    endcase
  end
  r.wr_en = ok && (r.dest != 5'd0);
  if (r.wr_en) begin
    model_regs[r.dest] = r.data;
  end
  return r;
endfunction

`endif

// ==== dv/mips_int_core_tb.sv ====
`timescale 1ns/1ns

module mips_int_core_tb;

  localparam int NUM_RANDOM  = 400;
  localparam int ACK_TIMEOUT = 20;
  localparam int END_TIMEOUT = 50;

  localparam logic [5:0] R_FUNCTS [16] = '{
    mips_pkg::FN_OR, mips_pkg::FN_AND, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
    mips_pkg::FN_SLLV, mips_pkg::FN_SRLV, mips_pkg::FN_SRAV, mips_pkg::FN_SLT,
    mips_pkg::FN_SLTU, mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
    mips_pkg::FN_SUBU, mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_SLT
  };
  localparam logic [5:0] SHIFT_FUNCTS [4] = '{
    mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA, mips_pkg::FN_SRA
  };
  localparam logic [5:0] I_OPS [8] = '{
    mips_pkg::OP_ORI, mips_pkg::OP_ANDI, mips_pkg::OP_XORI, mips_pkg::OP_LUI,
    mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU
  };
  // jump, beq, lw, sw
  localparam logic [5:0] BAD_OPS [4] = '{6'h02, 6'h04, 6'h23, 6'h2b};

  logic              clk = 1'b0;
  logic              rst;
  logic              inst_req;
  mips_pkg::word_t   inst;
  logic              inst_ack;
  logic              ret_valid;
  mips_pkg::retire_t ret;

  mips_pkg::word_t   accepted [$];
  mips_pkg::word_t   popped;
  mips_pkg::retire_t expected;
  int                sent = 0;
  int                retired = 0;

  `include "mips_ref_model.svh"

  mips_int_core i_mips_int_core (
    .clk_i       (clk),
    .rst_i       (rst),
    .inst_req_i  (inst_req),
    .inst_i      (inst),
    .inst_ack_o  (inst_ack),
    .ret_valid_o (ret_valid),
    .ret_o       (ret)
  );

  always #5 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Fail %s, inst %h: expected %h, actual %h", name, popped, exp, act);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // ack is sampled on the falling edge
  task automatic wait_ack(input logic level);
    int cycles;
    cycles = 0;
    while (inst_ack !== level) begin
      @(negedge clk);
      cycles++;
      assert (cycles <= ACK_TIMEOUT) else report_error("Handshake timeout waiting for ack");
    end
  endtask

  task automatic send(input mips_pkg::word_t word, input int gap);
    inst     = word;
    inst_req = 1'b1;
    wait_ack(1'b1);
    accepted.push_back(word);
    sent++;
    inst_req = 1'b0;
    wait_ack(1'b0);
    repeat (gap) @(negedge clk);
  endtask

  // mostly r0..r3 so that operands depend on recent results
  function automatic logic [4:0] pick_reg();
    if (rand_bits(3) < 6) begin
      return 5'(rand_bits(2));
    end
    return 5'(rand_bits(5));
  endfunction

  function automatic mips_pkg::word_t random_inst();
    logic [3:0]  cls;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    cls = 4'(rand_bits(4));
    rs  = pick_reg();
    rt  = pick_reg();
    rd  = pick_reg();
    imm = 16'(rand_bits(16));
    if (cls < 4'd6) begin
      return encode_r(R_FUNCTS[4'(rand_bits(4))], rs, rt, rd, 5'd0);
    end else if (cls < 4'd8) begin
      return encode_r(SHIFT_FUNCTS[2'(rand_bits(2))], 5'd0, rt, rd, imm[4:0]);
    end else if (cls < 4'd13) begin
      return encode_i(I_OPS[3'(rand_bits(3))], rs, rt, imm);
    end else if (cls == 4'd13) begin
      // register form with shamt set is unknown
      return encode_r(R_FUNCTS[imm[3:0]], rs, rt, rd, {1'b0, imm[7:4]} + 5'd1);
    end else if (cls == 4'd14) begin
      return encode_r(mips_pkg::FN_SLL, rs | 5'd1, rt, rd, imm[4:0]);
    end
    return encode_i(BAD_OPS[imm[1:0]], rs, rt, imm);
  endfunction

  always @(negedge clk) begin
    if (!rst && ret_valid) begin
      assert (accepted.size() > 0) else report_error("Retire record with no accepted instruction");
      popped   = accepted.pop_front();
      expected = ref_execute(popped);
      assert (ret.wr_en === expected.wr_en)
        else report_mismatch("retire_wr_en", 32'(expected.wr_en), 32'(ret.wr_en));
      // dest and data carry nothing without a write
      if (expected.wr_en) begin
        assert (ret.dest === expected.dest)
          else report_mismatch("retire_dest", 32'(expected.dest), 32'(ret.dest));
        assert (ret.data === expected.data)
          else report_mismatch("retire_data", expected.data, ret.data);
      end
      retired++;
    end
  end

  initial begin
    mips_pkg::word_t word;
    int              gap;
    int              wait_cycles;
    rst        = 1'b1;
    inst_req   = 1'b0;
    inst       = '0;
    lfsr_state = 32'ha9a0_ce3a;
    model_regs = '{default: '0};
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // negative source for the arithmetic shifts, fastest rate
    send(encode_i(mips_pkg::OP_LUI, 5'd0, 5'd1, 16'h8765), 0);
    send(encode_r(mips_pkg::FN_SRA, 5'd0, 5'd1, 5'd2, 5'd4), 0);
    send(encode_i(mips_pkg::OP_ADDIU, 5'd0, 5'd3, 16'hfff9), 0);
    send(encode_r(mips_pkg::FN_SRAV, 5'd3, 5'd1, 5'd3, 5'd0), 0);
    send(encode_r(mips_pkg::FN_SLL, 5'd2, 5'd1, 5'd2, 5'd3), 0);
    // r0 as target, then read back
    send(encode_i(mips_pkg::OP_ORI, 5'd1, 5'd0, 16'hffff), 0);
    send(encode_r(mips_pkg::FN_ADDU, 5'd0, 5'd0, 5'd2, 5'd0), 0);
    send(encode_i(mips_pkg::OP_SLTIU, 5'd1, 5'd3, 16'hffff), 1);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      word = random_inst();
      gap  = rand_bits(1) ? 0 : int'(rand_bits(3));
      send(word, gap);
    end

    wait_cycles = 0;
    while (retired < sent && wait_cycles < END_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (retired != sent) begin
      $display("Timeout: %0d of %0d retire records missing", sent - retired, sent);
      $display("Test FAILED");
      $fatal(1);
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
+incdir+dv
source/mips_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_stage.sv
source/alu_stage.sv
source/mips_int_core.sv
dv/mips_int_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, exit status is the simulator's
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mips_int_core_tb -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
fi
exit "$status"
